/* logic/kh_consts.svh */
`ifndef KH_CONSTS_SVH
`define KH_CONSTS_SVH

// Address bit that selects the helper register block
`define KH_REG_RANGE_BIT 17

// Control port widths
`define KH_CTRL_ADDR_W   32
// Kernel side address width, may be set below 32
`define KH_KERNEL_ADDR_W 32
`define KH_DATA_W        32

// Context id width
`define KH_CTXW          9

// Helper register offsets
`define KH_ADDR_KERNEL_TYPE   'h10
`define KH_ADDR_RELEASE_LEVEL 'h14
`define KH_ADDR_IRQ_SRC_LO    'h18
`define KH_ADDR_IRQ_SRC_HI    'h1C
`define KH_ADDR_CONTEXT       'h20
// Name word n sits at base + 4*n
`define KH_ADDR_NAME_BASE     'h30

// Kernel identity
`define KH_KERNEL_TYPE   32'h0000_4B48
`define KH_RELEASE_LEVEL 32'h0000_0003

// Kernel name, four ASCII characters per word
`define KH_NAME_STR1 32'h6E72_656B
`define KH_NAME_STR2 32'h685F_6C65
`define KH_NAME_STR3 32'h7265_706C
`define KH_NAME_STR4 32'h2020_2020
`define KH_NAME_STR5 32'h2020_2020
`define KH_NAME_STR6 32'h2020_2020
`define KH_NAME_STR7 32'h2020_2020
`define KH_NAME_STR8 32'h2020_2020

`endif

/* logic/kh_pkg.sv */
`include "kh_consts.svh"

package kh_pkg;

    // Infrastructure side address
    typedef logic [`KH_CTRL_ADDR_W-1:0] ctrl_addr_t;

    // Kernel side address, trimmed
    typedef logic [`KH_KERNEL_ADDR_W-1:0] kernel_addr_t;

    // Offset inside the helper register block
    typedef logic [`KH_REG_RANGE_BIT-1:0] helper_addr_t;

    typedef logic [`KH_DATA_W-1:0] data_t;

    typedef logic [`KH_DATA_W/8-1:0] strb_t;

    typedef logic [1:0] resp_t;

    typedef logic [`KH_CTXW-1:0] ctx_t;

    // Interrupt source address, high word on top
    typedef logic [2*`KH_DATA_W-1:0] irq_src_t;

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_DATA,
        WR_RESP
    } wr_state_t;

    typedef enum logic {
        RD_IDLE,
        RD_DATA
    } rd_state_t;

endpackage

/* logic/ctrl_addr_router.sv */
`timescale 1ns/1ps

`include "kh_consts.svh"

module ctrl_addr_router import kh_pkg::*; (
    input  logic         ACLK,
    input  logic         ARESET,

    input  logic         i2h_awvalid,
    output logic         i2h_awready,
    input  ctrl_addr_t   i2h_awaddr,
    input  logic         i2h_wvalid,
    output logic         i2h_wready,
    input  data_t        i2h_wdata,
    input  strb_t        i2h_wstrb,
    output logic         i2h_bvalid,
    input  logic         i2h_bready,
    output resp_t        i2h_bresp,
    input  logic         i2h_arvalid,
    output logic         i2h_arready,
    input  ctrl_addr_t   i2h_araddr,
    output logic         i2h_rvalid,
    input  logic         i2h_rready,
    output data_t        i2h_rdata,
    output resp_t        i2h_rresp,

    output logic         h2k_awvalid,
    input  logic         h2k_awready,
    output kernel_addr_t h2k_awaddr,
    output logic         h2k_wvalid,
    input  logic         h2k_wready,
    output data_t        h2k_wdata,
    output strb_t        h2k_wstrb,
    input  logic         h2k_bvalid,
    output logic         h2k_bready,
    input  resp_t        h2k_bresp,
    output logic         h2k_arvalid,
    input  logic         h2k_arready,
    output kernel_addr_t h2k_araddr,
    input  logic         h2k_rvalid,
    output logic         h2k_rready,
    input  data_t        h2k_rdata,
    input  resp_t        h2k_rresp,

    output logic         hlp_awvalid,
    input  logic         hlp_awready,
    output logic         hlp_wvalid,
    input  logic         hlp_wready,
    input  logic         hlp_bvalid,
    output logic         hlp_arvalid,
    input  logic         hlp_arready,
    input  logic         hlp_rvalid,
    input  data_t        hlp_rdata
);

    // Helper registers always answer OKAY
    localparam resp_t RESP_OKAY = 2'b00;

    logic aw_hlp;
    logic ar_hlp;
    logic aw_hlp_q;
    logic w_hlp;

    assign aw_hlp = i2h_awaddr[`KH_REG_RANGE_BIT];
    assign ar_hlp = i2h_araddr[`KH_REG_RANGE_BIT];

    // Remember where the last write address went, W may trail AW
    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            aw_hlp_q <= 1'b0;
        end else if (i2h_awvalid) begin
            aw_hlp_q <= aw_hlp;
        end
    end

    assign w_hlp = i2h_awvalid ? aw_hlp : aw_hlp_q;

    // Write address
    assign hlp_awvalid = i2h_awvalid & aw_hlp;
    assign h2k_awvalid = i2h_awvalid & ~aw_hlp;
    assign i2h_awready = aw_hlp ? hlp_awready : h2k_awready;
    assign h2k_awaddr  = i2h_awaddr[`KH_KERNEL_ADDR_W-1:0];

    // Write data
    assign hlp_wvalid = i2h_wvalid & w_hlp;
    assign h2k_wvalid = i2h_wvalid & ~w_hlp;
    assign i2h_wready = w_hlp ? hlp_wready : h2k_wready;
    assign h2k_wdata  = i2h_wdata;
    assign h2k_wstrb  = i2h_wstrb;

    // Write response, only one side is active at a time
    assign i2h_bvalid = hlp_bvalid | h2k_bvalid;
    assign i2h_bresp  = hlp_bvalid ? RESP_OKAY : h2k_bresp;
    assign h2k_bready = i2h_bready;

    // Read address
    assign hlp_arvalid = i2h_arvalid & ar_hlp;
    assign h2k_arvalid = i2h_arvalid & ~ar_hlp;
    assign i2h_arready = ar_hlp ? hlp_arready : h2k_arready;
    assign h2k_araddr  = i2h_araddr[`KH_KERNEL_ADDR_W-1:0];

    // Read data
    assign i2h_rvalid = hlp_rvalid | h2k_rvalid;
    assign i2h_rdata  = hlp_rvalid ? hlp_rdata : h2k_rdata;
    assign i2h_rresp  = hlp_rvalid ? RESP_OKAY : h2k_rresp;
    assign h2k_rready = i2h_rready;

endmodule

/* logic/helper_reg_write.sv */
`timescale 1ns/1ps

`include "kh_consts.svh"

module helper_reg_write import kh_pkg::*; (
    input  logic         ACLK,
    input  logic         ARESET,
    input  logic         awvalid,
    input  helper_addr_t awaddr,
    output logic         awready,
    input  logic         wvalid,
    input  data_t        wdata,
    output logic         wready,
    output logic         bvalid,
    input  logic         bready,
    output ctx_t         ctx,
    output irq_src_t     irq_src
);

    wr_state_t    state;
    wr_state_t    state_nxt;
    helper_addr_t waddr;
    logic         aw_hs;
    logic         w_hs;

    assign awready = (state == WR_IDLE);
    assign wready  = (state == WR_DATA);
    assign bvalid  = (state == WR_RESP);

    assign aw_hs = awvalid & awready;
    assign w_hs  = wvalid & wready;

    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            state <= WR_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            WR_IDLE: begin
                if (aw_hs) begin
                    state_nxt = WR_DATA;
                end
            end
            WR_DATA: begin
                if (w_hs) begin
                    state_nxt = WR_RESP;
                end
            end
            WR_RESP: begin
                if (bready) begin
                    state_nxt = WR_IDLE;
                end
            end
            default: state_nxt = WR_IDLE;
        endcase
    end

    // Offset held for the data phase
    always_ff @(posedge ACLK) begin
        if (aw_hs) begin
            waddr <= awaddr;
        end
    end

    // Only context and the two source halves are writable
    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            ctx     <= '0;
            irq_src <= '0;
        end else if (w_hs) begin
            if (waddr == helper_addr_t'(`KH_ADDR_CONTEXT)) begin
                ctx <= wdata[`KH_CTXW-1:0];
            end
            if (waddr == helper_addr_t'(`KH_ADDR_IRQ_SRC_LO)) begin
                irq_src[`KH_DATA_W-1:0] <= wdata;
            end
            if (waddr == helper_addr_t'(`KH_ADDR_IRQ_SRC_HI)) begin
                irq_src[2*`KH_DATA_W-1:`KH_DATA_W] <= wdata;
            end
        end
    end

endmodule

/* logic/helper_reg_read.sv */
`timescale 1ns/1ps

`include "kh_consts.svh"

module helper_reg_read import kh_pkg::*; (
    input  logic         ACLK,
    input  logic         ARESET,
    input  logic         arvalid,
    input  helper_addr_t araddr,
    output logic         arready,
    output logic         rvalid,
    input  logic         rready,
    output data_t        rdata,
    input  ctx_t         ctx
);

    localparam data_t NAME_WORDS [8] = '{
        `KH_NAME_STR1, `KH_NAME_STR2, `KH_NAME_STR3, `KH_NAME_STR4,
        `KH_NAME_STR5, `KH_NAME_STR6, `KH_NAME_STR7, `KH_NAME_STR8
    };

    rd_state_t    state;
    helper_addr_t name_off;
    data_t        rd_word;
    logic         ar_hs;

    assign arready = (state == RD_IDLE);
    assign rvalid  = (state == RD_DATA);
    assign ar_hs   = arvalid & arready;

    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            state <= RD_IDLE;
        end else begin
            case (state)
                RD_IDLE: begin
                    if (ar_hs) begin
                        state <= RD_DATA;
                    end
                end
                RD_DATA: begin
                    if (rready) begin
                        state <= RD_IDLE;
                    end
                end
                default: state <= RD_IDLE;
            endcase
        end
    end

    // Below the name base this wraps high and misses the window
    assign name_off = araddr - helper_addr_t'(`KH_ADDR_NAME_BASE);

    always_comb begin
        rd_word = '0;
        if (araddr == helper_addr_t'(`KH_ADDR_KERNEL_TYPE)) begin
            rd_word = `KH_KERNEL_TYPE;
        end else if (araddr == helper_addr_t'(`KH_ADDR_RELEASE_LEVEL)) begin
            rd_word = `KH_RELEASE_LEVEL;
        end else if (araddr == helper_addr_t'(`KH_ADDR_CONTEXT)) begin
            rd_word = data_t'(ctx);
        end else if (name_off < helper_addr_t'(8 * 4) && name_off[1:0] == 2'b00) begin
            rd_word = NAME_WORDS[name_off[4:2]];
        end
    end

    // Data captured at the address handshake, held until taken
    always_ff @(posedge ACLK) begin
        if (ar_hs) begin
            rdata <= rd_word;
        end
    end

endmodule

/* logic/irq_handshake.sv */
`timescale 1ns/1ps

module irq_handshake (
    input  logic ACLK,
    input  logic ARESET,
    input  logic irq_in,
    input  logic irq_ack,
    output logic irq_req
);

    // Current level already turned into a request
    logic latched_q;
    // A request is out and not yet acknowledged
    logic wait_ack_q;

    assign irq_req = irq_in & ~latched_q;

    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            latched_q  <= 1'b0;
            wait_ack_q <= 1'b0;
        end else begin
            wait_ack_q <= (wait_ack_q & ~irq_ack) | (irq_req & ~wait_ack_q);
            // While an ack is pending a new level is held until irq_ack
            latched_q  <= irq_in & (latched_q | ~wait_ack_q | irq_ack);
        end
    end

endmodule

/* logic/kernel_helper_top.sv */
`timescale 1ns/1ps

`include "kh_consts.svh"

module kernel_helper_top import kh_pkg::*; (
    input  logic         ACLK,
    input  logic         ARESET,

    // Control port from the infrastructure
    input  logic         i2h_awvalid,
    output logic         i2h_awready,
    input  ctrl_addr_t   i2h_awaddr,
    input  logic         i2h_wvalid,
    output logic         i2h_wready,
    input  data_t        i2h_wdata,
    input  strb_t        i2h_wstrb,
    output logic         i2h_bvalid,
    input  logic         i2h_bready,
    output resp_t        i2h_bresp,
    input  logic         i2h_arvalid,
    output logic         i2h_arready,
    input  ctrl_addr_t   i2h_araddr,
    output logic         i2h_rvalid,
    input  logic         i2h_rready,
    output data_t        i2h_rdata,
    output resp_t        i2h_rresp,

    // Control port to the kernel core
    output logic         h2k_awvalid,
    input  logic         h2k_awready,
    output kernel_addr_t h2k_awaddr,
    output logic         h2k_wvalid,
    input  logic         h2k_wready,
    output data_t        h2k_wdata,
    output strb_t        h2k_wstrb,
    input  logic         h2k_bvalid,
    output logic         h2k_bready,
    input  resp_t        h2k_bresp,
    output logic         h2k_arvalid,
    input  logic         h2k_arready,
    output kernel_addr_t h2k_araddr,
    input  logic         h2k_rvalid,
    output logic         h2k_rready,
    input  data_t        h2k_rdata,
    input  resp_t        h2k_rresp,

    // Interrupt
    input  logic         irq_in,
    output logic         irq_req,
    output irq_src_t     irq_src,
    output ctx_t         irq_ctx,
    input  logic         irq_ack
);

    logic  hlp_awvalid;
    logic  hlp_awready;
    logic  hlp_wvalid;
    logic  hlp_wready;
    logic  hlp_bvalid;
    logic  hlp_arvalid;
    logic  hlp_arready;
    logic  hlp_rvalid;
    data_t hlp_rdata;

    ctrl_addr_router u_router (
        .ACLK        (ACLK),
        .ARESET      (ARESET),
        .i2h_awvalid (i2h_awvalid),
        .i2h_awready (i2h_awready),
        .i2h_awaddr  (i2h_awaddr),
        .i2h_wvalid  (i2h_wvalid),
        .i2h_wready  (i2h_wready),
        .i2h_wdata   (i2h_wdata),
        .i2h_wstrb   (i2h_wstrb),
        .i2h_bvalid  (i2h_bvalid),
        .i2h_bready  (i2h_bready),
        .i2h_bresp   (i2h_bresp),
        .i2h_arvalid (i2h_arvalid),
        .i2h_arready (i2h_arready),
        .i2h_araddr  (i2h_araddr),
        .i2h_rvalid  (i2h_rvalid),
        .i2h_rready  (i2h_rready),
        .i2h_rdata   (i2h_rdata),
        .i2h_rresp   (i2h_rresp),
        .h2k_awvalid (h2k_awvalid),
        .h2k_awready (h2k_awready),
        .h2k_awaddr  (h2k_awaddr),
        .h2k_wvalid  (h2k_wvalid),
        .h2k_wready  (h2k_wready),
        .h2k_wdata   (h2k_wdata),
        .h2k_wstrb   (h2k_wstrb),
        .h2k_bvalid  (h2k_bvalid),
        .h2k_bready  (h2k_bready),
        .h2k_bresp   (h2k_bresp),
        .h2k_arvalid (h2k_arvalid),
        .h2k_arready (h2k_arready),
        .h2k_araddr  (h2k_araddr),
        .h2k_rvalid  (h2k_rvalid),
        .h2k_rready  (h2k_rready),
        .h2k_rdata   (h2k_rdata),
        .h2k_rresp   (h2k_rresp),
        .hlp_awvalid (hlp_awvalid),
        .hlp_awready (hlp_awready),
        .hlp_wvalid  (hlp_wvalid),
        .hlp_wready  (hlp_wready),
        .hlp_bvalid  (hlp_bvalid),
        .hlp_arvalid (hlp_arvalid),
        .hlp_arready (hlp_arready),
        .hlp_rvalid  (hlp_rvalid),
        .hlp_rdata   (hlp_rdata)
    );

    // Helper sees only the offset below the range bit
    helper_reg_write u_reg_write (
        .ACLK    (ACLK),
        .ARESET  (ARESET),
        .awvalid (hlp_awvalid),
        .awaddr  (i2h_awaddr[`KH_REG_RANGE_BIT-1:0]),
        .awready (hlp_awready),
        .wvalid  (hlp_wvalid),
        .wdata   (i2h_wdata),
        .wready  (hlp_wready),
        .bvalid  (hlp_bvalid),
        .bready  (i2h_bready),
        .ctx     (irq_ctx),
        .irq_src (irq_src)
    );

    helper_reg_read u_reg_read (
        .ACLK    (ACLK),
        .ARESET  (ARESET),
        .arvalid (hlp_arvalid),
        .araddr  (i2h_araddr[`KH_REG_RANGE_BIT-1:0]),
        .arready (hlp_arready),
        .rvalid  (hlp_rvalid),
        .rready  (i2h_rready),
        .rdata   (hlp_rdata),
        .ctx     (irq_ctx)
    );

    irq_handshake u_irq (
        .ACLK    (ACLK),
        .ARESET  (ARESET),
        .irq_in  (irq_in),
        .irq_ack (irq_ack),
        .irq_req (irq_req)
    );

endmodule

/* sim/tb_kernel_helper.sv */
`timescale 1ns/1ps

`include "kh_consts.svh"

module tb_kernel_helper import kh_pkg::*; ();

    localparam int CLK_PERIOD    = 40;
    localparam int RESET_CYCLES  = 8;
    localparam int N_KERNEL      = 16;
    // Accesses per test: identity, write/readback, pass-through, unmapped
    localparam int N_ACCESS      = 11 + 16 + (2 * N_KERNEL + 1) + 16;
    localparam int ACCESS_CYCLES = 24;
    localparam int IRQ_CYCLES    = 40;
    localparam int MAX_CYCLES    = RESET_CYCLES + N_ACCESS * ACCESS_CYCLES + IRQ_CYCLES + 128;

    logic         ACLK;
    logic         ARESET;
    logic         i2h_awvalid;
    logic         i2h_awready;
    ctrl_addr_t   i2h_awaddr;
    logic         i2h_wvalid;
    logic         i2h_wready;
    data_t        i2h_wdata;
    strb_t        i2h_wstrb;
    logic         i2h_bvalid;
    logic         i2h_bready;
    resp_t        i2h_bresp;
    logic         i2h_arvalid;
    logic         i2h_arready;
    ctrl_addr_t   i2h_araddr;
    logic         i2h_rvalid;
    logic         i2h_rready;
    data_t        i2h_rdata;
    resp_t        i2h_rresp;
    logic         h2k_awvalid;
    logic         h2k_awready;
    kernel_addr_t h2k_awaddr;
    logic         h2k_wvalid;
    logic         h2k_wready;
    data_t        h2k_wdata;
    strb_t        h2k_wstrb;
    logic         h2k_bvalid;
    logic         h2k_bready;
    resp_t        h2k_bresp;
    logic         h2k_arvalid;
    logic         h2k_arready;
    kernel_addr_t h2k_araddr;
    logic         h2k_rvalid;
    logic         h2k_rready;
    data_t        h2k_rdata;
    resp_t        h2k_rresp;
    logic         irq_in;
    logic         irq_req;
    irq_src_t     irq_src;
    ctx_t         irq_ctx;
    logic         irq_ack;

    integer       seed = 32'haaac3e71;
    int           errors = 0;
    int           checks = 0;
    int           cycle_count = 0;

    // Expected helper register contents
    ctx_t         model_ctx = '0;
    irq_src_t     model_src = '0;

    // What the kernel model saw
    kernel_addr_t kern_awaddr;
    data_t        kern_wdata;
    strb_t        kern_wstrb;
    kernel_addr_t kern_araddr;
    int           kern_aw_count = 0;
    int           exp_kern_writes = 0;
    logic         have_aw;
    logic         have_w;
    logic         have_ar;
    logic         b_taken;
    logic         r_taken;

    // Read addresses waiting for their data beat
    ctrl_addr_t   rd_addr_q [$];

    kernel_helper_top DUT (.*);

    initial begin
        ACLK = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) ACLK = ~ACLK;
        end
    end

    initial begin
        while (cycle_count < MAX_CYCLES) begin
            @(posedge ACLK);
            cycle_count++;
        end
        $display("Timeout: run stopped after %0d cycles", cycle_count);
        $display("tests failed");
        $finish;
    end

    function automatic ctrl_addr_t helper_addr(input int unsigned off);
        return ctrl_addr_t'(off) | (ctrl_addr_t'(1) << `KH_REG_RANGE_BIT);
    endfunction

    // Kernel read pattern, every address bit affects the word
    function automatic data_t kernel_read_value(input kernel_addr_t kaddr);
        return (data_t'(kaddr) * 32'h9E37_79B9) ^ 32'h5A5A_C3C3;
    endfunction

    function automatic data_t name_word(input int idx);
        case (idx)
            0: return `KH_NAME_STR1;
            1: return `KH_NAME_STR2;
            2: return `KH_NAME_STR3;
            3: return `KH_NAME_STR4;
            4: return `KH_NAME_STR5;
            5: return `KH_NAME_STR6;
            6: return `KH_NAME_STR7;
            default: return `KH_NAME_STR8;
        endcase
    endfunction

    function automatic data_t kh_expect_read(input ctrl_addr_t addr);
        helper_addr_t off;
        data_t        word;
        off  = addr[`KH_REG_RANGE_BIT-1:0];
        word = '0;
        if (!addr[`KH_REG_RANGE_BIT]) begin
            word = kernel_read_value(addr[`KH_KERNEL_ADDR_W-1:0]);
        end else if (off == `KH_ADDR_KERNEL_TYPE) begin
            word = `KH_KERNEL_TYPE;
        end else if (off == `KH_ADDR_RELEASE_LEVEL) begin
            word = `KH_RELEASE_LEVEL;
        end else if (off == `KH_ADDR_CONTEXT) begin
            word = data_t'(model_ctx);
        end else begin
            // Interrupt source is write only, so it falls through to zero
            for (int i = 0; i < 8; i++) begin
                if (off == `KH_ADDR_NAME_BASE + 4 * i) begin
                    word = name_word(i);
                end
            end
        end
        return word;
    endfunction

    function automatic int unmapped_offset(input int idx);
        case (idx)
            0: return 'h00;
            1: return 'h04;
            2: return `KH_ADDR_IRQ_SRC_LO;
            3: return `KH_ADDR_IRQ_SRC_HI;
            4: return 'h24;
            5: return 'h2C;
            6: return 'h50;
            default: return 'h1_FFFC;
        endcase
    endfunction

    function automatic int read_only_offset(input int idx);
        case (idx)
            0: return `KH_ADDR_KERNEL_TYPE;
            1: return `KH_ADDR_RELEASE_LEVEL;
            2: return `KH_ADDR_NAME_BASE;
            3: return `KH_ADDR_NAME_BASE + 'h1C;
            4: return 'h04;
            default: return 'h100;
        endcase
    endfunction

    task automatic update_model(input ctrl_addr_t addr, input data_t data);
        helper_addr_t off;
        off = addr[`KH_REG_RANGE_BIT-1:0];
        if (off == `KH_ADDR_CONTEXT) begin
            model_ctx = data[`KH_CTXW-1:0];
        end else if (off == `KH_ADDR_IRQ_SRC_LO) begin
            model_src[`KH_DATA_W-1:0] = data;
        end else if (off == `KH_ADDR_IRQ_SRC_HI) begin
            model_src[2*`KH_DATA_W-1:`KH_DATA_W] = data;
        end
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic write_access(input ctrl_addr_t addr, input data_t data);
        strb_t strb;
        strb = addr[`KH_REG_RANGE_BIT] ? 4'hF : strb_t'($random(seed));
        @(negedge ACLK);
        i2h_awvalid = 1'b1;
        i2h_awaddr  = addr;
        #1;
        while (!i2h_awready) begin
            @(negedge ACLK);
            #1;
        end
        @(negedge ACLK);
        i2h_awvalid = 1'b0;
        i2h_wvalid  = 1'b1;
        i2h_wdata   = data;
        i2h_wstrb   = strb;
        #1;
        while (!i2h_wready) begin
            @(negedge ACLK);
            #1;
        end
        @(negedge ACLK);
        i2h_wvalid = 1'b0;
        i2h_bready = 1'b1;
        #1;
        while (!i2h_bvalid) begin
            @(negedge ACLK);
            #1;
        end
        // Kernel responses pass through unchanged, the helper answers OKAY
        check_value("i2h_bresp", i2h_bresp, addr[`KH_REG_RANGE_BIT] ? 2'b00 : h2k_bresp);
        @(negedge ACLK);
        i2h_bready = 1'b0;
        if (addr[`KH_REG_RANGE_BIT]) begin
            update_model(addr, data);
        end else begin
            exp_kern_writes++;
            check_value("h2k_awaddr", kern_awaddr, addr[`KH_KERNEL_ADDR_W-1:0]);
            check_value("h2k_wdata", kern_wdata, data);
            check_value("h2k_wstrb", kern_wstrb, strb);
        end
        check_value("kernel write count", kern_aw_count, exp_kern_writes);
    endtask

    task automatic read_access(input ctrl_addr_t addr);
        @(negedge ACLK);
        i2h_arvalid = 1'b1;
        i2h_araddr  = addr;
        #1;
        while (!i2h_arready) begin
            @(negedge ACLK);
            #1;
        end
        rd_addr_q.push_back(addr);
        @(negedge ACLK);
        i2h_arvalid = 1'b0;
        i2h_rready  = 1'b1;
        #1;
        while (!i2h_rvalid) begin
            @(negedge ACLK);
            #1;
        end
        @(negedge ACLK);
        i2h_rready = 1'b0;
        if (!addr[`KH_REG_RANGE_BIT]) begin
            check_value("h2k_araddr", kern_araddr, addr[`KH_KERNEL_ADDR_W-1:0]);
        end
    endtask

    task automatic irq_step(input logic level, input logic ack, input logic exp_req);
        @(negedge ACLK);
        irq_in  = level;
        irq_ack = ack;
        #1;
        check_value("irq_req", irq_req, exp_req);
    endtask

    task automatic end_test(input string name, input int err_before);
        if (errors == err_before) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, errors - err_before);
        end
    endtask

    // Kernel core model with random back-pressure
    initial begin
        h2k_awready = 1'b0;
        h2k_wready  = 1'b0;
        h2k_bvalid  = 1'b0;
        h2k_bresp   = 2'b00;
        h2k_arready = 1'b0;
        h2k_rvalid  = 1'b0;
        h2k_rdata   = '0;
        h2k_rresp   = 2'b00;
        forever begin
            @(negedge ACLK);
            if (ARESET) begin
                have_aw     = 1'b0;
                have_w      = 1'b0;
                have_ar     = 1'b0;
                b_taken     = 1'b0;
                r_taken     = 1'b0;
                h2k_awready = 1'b0;
                h2k_wready  = 1'b0;
                h2k_arready = 1'b0;
                h2k_bvalid  = 1'b0;
                h2k_rvalid  = 1'b0;
            end else begin
                if (b_taken) begin
                    h2k_bvalid = 1'b0;
                end
                if (r_taken) begin
                    h2k_rvalid = 1'b0;
                end
                if (have_aw && have_w && !h2k_bvalid) begin
                    h2k_bvalid = 1'b1;
                    h2k_bresp  = resp_t'($random(seed));
                    have_aw    = 1'b0;
                    have_w     = 1'b0;
                end
                if (have_ar && !h2k_rvalid) begin
                    h2k_rvalid = 1'b1;
                    h2k_rdata  = kernel_read_value(kern_araddr);
                    h2k_rresp  = resp_t'($random(seed));
                    have_ar    = 1'b0;
                end
                h2k_awready = ($random(seed) % 4) != 0;
                h2k_wready  = ($random(seed) % 4) != 0;
                h2k_arready = ($random(seed) % 4) != 0;
                #1;
                b_taken = h2k_bvalid && h2k_bready;
                r_taken = h2k_rvalid && h2k_rready;
                if (h2k_awvalid && h2k_awready) begin
                    kern_awaddr = h2k_awaddr;
                    have_aw     = 1'b1;
                    kern_aw_count++;
                end
                if (h2k_wvalid && h2k_wready) begin
                    kern_wdata = h2k_wdata;
                    kern_wstrb = h2k_wstrb;
                    have_w     = 1'b1;
                end
                if (h2k_arvalid && h2k_arready) begin
                    kern_araddr = h2k_araddr;
                    have_ar     = 1'b1;
                end
            end
        end
    end

    // Every R beat is compared with the reference read
    initial begin
        ctrl_addr_t rd_addr;
        forever begin
            @(negedge ACLK);
            #1;
            if (i2h_rvalid && i2h_rready) begin
                checks++;
                assert (rd_addr_q.size() != 0) else begin
                    $display("Read data beat arrived with no read outstanding");
                    errors++;
                end
                if (rd_addr_q.size() != 0) begin
                    rd_addr = rd_addr_q.pop_front();
                    check_value("i2h_rdata", i2h_rdata, kh_expect_read(rd_addr));
                    check_value("i2h_rresp", i2h_rresp,
                                rd_addr[`KH_REG_RANGE_BIT] ? 2'b00 : h2k_rresp);
                end
            end
        end
    end

    initial begin
        ctrl_addr_t addr;
        int         err_before;
        ARESET      = 1'b1;
        i2h_awvalid = 1'b0;
        i2h_awaddr  = '0;
        i2h_wvalid  = 1'b0;
        i2h_wdata   = '0;
        i2h_wstrb   = '0;
        i2h_bready  = 1'b0;
        i2h_arvalid = 1'b0;
        i2h_araddr  = '0;
        i2h_rready  = 1'b0;
        irq_in      = 1'b0;
        irq_ack     = 1'b0;
        repeat (RESET_CYCLES) @(posedge ACLK);
        @(negedge ACLK);
        ARESET = 1'b0;

        // Identity registers and reset state
        err_before = errors;
        read_access(helper_addr(`KH_ADDR_KERNEL_TYPE));
        read_access(helper_addr(`KH_ADDR_RELEASE_LEVEL));
        for (int i = 0; i < 8; i++) begin
            read_access(helper_addr(`KH_ADDR_NAME_BASE + 4 * i));
        end
        read_access(helper_addr(`KH_ADDR_CONTEXT));
        check_value("irq_ctx", irq_ctx, '0);
        check_value("irq_src", irq_src, '0);
        check_value("irq_req", irq_req, 1'b0);
        end_test("test 1 reset values", err_before);

        err_before = errors;
        for (int i = 0; i < 4; i++) begin
            write_access(helper_addr(`KH_ADDR_CONTEXT), $random(seed));
            write_access(helper_addr(`KH_ADDR_IRQ_SRC_LO), $random(seed));
            write_access(helper_addr(`KH_ADDR_IRQ_SRC_HI), $random(seed));
            read_access(helper_addr(`KH_ADDR_CONTEXT));
            check_value("irq_ctx", irq_ctx, model_ctx);
            check_value("irq_src", irq_src, model_src);
        end
        end_test("test 2 context and irq source", err_before);

        // Range bit clear goes to the kernel
        err_before = errors;
        for (int i = 0; i < N_KERNEL; i++) begin
            addr = $random(seed);
            addr[`KH_REG_RANGE_BIT] = 1'b0;
            addr[1:0] = 2'b00;
            write_access(addr, $random(seed));
            addr = $random(seed);
            addr[`KH_REG_RANGE_BIT] = 1'b0;
            addr[1:0] = 2'b00;
            read_access(addr);
        end
        check_value("irq_ctx", irq_ctx, model_ctx);
        check_value("irq_src", irq_src, model_src);
        read_access(helper_addr(`KH_ADDR_CONTEXT));
        end_test("test 3 kernel pass-through", err_before);

        err_before = errors;
        for (int i = 0; i < 8; i++) begin
            read_access(helper_addr(unmapped_offset(i)));
        end
        for (int i = 0; i < 6; i++) begin
            write_access(helper_addr(read_only_offset(i)), $random(seed));
        end
        check_value("irq_ctx", irq_ctx, model_ctx);
        check_value("irq_src", irq_src, model_src);
        read_access(helper_addr(`KH_ADDR_CONTEXT));
        read_access(helper_addr(`KH_ADDR_KERNEL_TYPE));
        end_test("test 4 unmapped and read-only", err_before);

        // Single pulse, then a held request while the ack is pending
        err_before = errors;
        irq_step(1'b0, 1'b0, 1'b0);
        irq_step(1'b1, 1'b0, 1'b1);
        irq_step(1'b1, 1'b0, 1'b0);
        irq_step(1'b1, 1'b0, 1'b0);
        irq_step(1'b0, 1'b0, 1'b0);
        irq_step(1'b1, 1'b0, 1'b1);
        irq_step(1'b1, 1'b0, 1'b1);
        irq_step(1'b1, 1'b0, 1'b1);
        irq_step(1'b1, 1'b1, 1'b1);
        irq_step(1'b1, 1'b0, 1'b0);
        irq_step(1'b0, 1'b0, 1'b0);
        irq_step(1'b1, 1'b0, 1'b1);
        irq_step(1'b1, 1'b0, 1'b0);
        irq_step(1'b0, 1'b1, 1'b0);
        irq_step(1'b0, 1'b0, 1'b0);
        end_test("test 5 interrupt handshake", err_before);

        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* kernel_helper.f */
+incdir+logic
logic/kh_pkg.sv
logic/ctrl_addr_router.sv
logic/helper_reg_write.sv
logic/helper_reg_read.sv
logic/irq_handshake.sv
logic/kernel_helper_top.sv
sim/tb_kernel_helper.sv
